/* hw/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// LSQ request ports into the request queue
`define DC_PORTS 2

`define DC_QUEUE_DEPTH 8

// Outstanding memory transactions
`define DC_MSHRS 4

// Direct-mapped, one word per line
`define DC_LINES 16

// Address split is tag, index, word offset
`define DC_TAG_BITS 26
`define DC_INDEX_BITS 4
`define DC_OFFSET_BITS 2

`define DC_REQ_ID_BITS 4

`endif

/* hw/dcache_pkg.sv */
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [`DC_TAG_BITS-1:0] line_tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] line_index_t;
    typedef logic [`DC_REQ_ID_BITS-1:0] req_id_t;

    // Zero means no transaction
    typedef logic [3:0] mem_tag_t;

    // Allocation order of miss entries, one bit wider than needed
    typedef logic [$clog2(`DC_MSHRS):0] miss_order_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_command_t;

    typedef struct packed {
        logic    is_store;
        req_id_t id;
        addr_t   addr;
        word_t   data;
    } dc_req_t;

    typedef struct packed {
        req_id_t id;
        word_t   data;
    } dc_resp_t;

    typedef struct packed {
        logic        valid;
        logic        issued;
        logic        squashed;
        logic        is_store;
        miss_order_t order;
        mem_tag_t    mem_tag;
        req_id_t     id;
        addr_t       addr;
        word_t       data;
    } miss_entry_t;

    function automatic line_tag_t addr_tag(addr_t addr);
        return addr[31 -: `DC_TAG_BITS];
    endfunction

    function automatic line_index_t addr_index(addr_t addr);
        return addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    endfunction

endpackage

`default_nettype wire

/* hw/req_queue.sv */
`default_nettype none

`include "dcache_config.svh"

module req_queue
    import dcache_pkg::*;
#(
    parameter int DEPTH = `DC_QUEUE_DEPTH
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  logic    [`DC_PORTS-1:0]  push_valid,
    input  dc_req_t [`DC_PORTS-1:0]  push_req,
    input  logic                     pop,
    output logic    [`DC_PORTS-1:0]  push_accept,
    output logic                     head_valid,
    output dc_req_t                  head_req
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] count_t;

    dc_req_t slots [DEPTH];
    ptr_t    head;
    ptr_t    tail;
    count_t  count;

    ptr_t    wr_ptr [`DC_PORTS];
    ptr_t    tail_next;
    count_t  push_count;
    logic    pop_ok;

    function automatic ptr_t ptr_inc(ptr_t ptr);
        if (ptr == ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_req   = slots[head];
    assign pop_ok     = pop && head_valid;

    // Room is taken from occupancy at the start of the cycle, port 0 first
    always_comb begin
        count_t room;
        ptr_t   wr;
        room       = count_t'(DEPTH) - count;
        wr         = tail;
        push_count = '0;
        for (int p = 0; p < `DC_PORTS; p++) begin
            push_accept[p] = push_valid[p] && !squash && (room != '0);
            wr_ptr[p]      = wr;
            if (push_accept[p]) begin
                room       = room - 1'b1;
                wr         = ptr_inc(wr);
                push_count = push_count + 1'b1;
            end
        end
        tail_next = wr;
    end

    always_ff @(posedge clock) begin
        for (int p = 0; p < `DC_PORTS; p++) begin
            if (push_accept[p]) begin
                slots[wr_ptr[p]] <= push_req[p];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail_next;
            count <= count + push_count - count_t'(pop_ok);
            if (pop_ok) begin
                head <= ptr_inc(head);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_lookup.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        squash,
    input  logic        q_valid,
    input  dc_req_t     q_req,
    input  logic        line_busy,
    input  logic        miss_ready,
    input  logic        fill_valid,
    input  line_index_t fill_index,
    input  line_tag_t   fill_tag,
    input  word_t       fill_data,
    output logic        q_ready,
    output line_tag_t   probe_tag,
    output line_index_t probe_index,
    output logic        hit_valid,
    output dc_resp_t    hit_resp,
    output logic        miss_valid,
    output dc_req_t     miss_req
);

    logic [`DC_LINES-1:0] line_valid;
    line_tag_t            line_tag  [`DC_LINES];
    word_t                line_word [`DC_LINES];

    logic is_hit;
    logic to_miss_path;
    logic store_hit;
    logic load_hit;

    assign probe_tag   = addr_tag(q_req.addr);
    assign probe_index = addr_index(q_req.addr);

    assign is_hit = line_valid[probe_index] && (line_tag[probe_index] == probe_tag);

    // Stores always write through, loads only on a miss
    assign to_miss_path = q_req.is_store || !is_hit;
    assign store_hit    = q_req.is_store && is_hit;
    assign load_hit     = !q_req.is_store && is_hit;

    // One write port on the line array, so a fill holds off a store hit
    always_comb begin
        q_ready = q_valid && !squash && !line_busy;
        if (to_miss_path && !miss_ready) begin
            q_ready = 1'b0;
        end
        if (store_hit && fill_valid) begin
            q_ready = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_valid) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            line_tag[fill_index]  <= fill_tag;
            line_word[fill_index] <= fill_data;
        end else if (q_ready && store_hit) begin
            line_word[probe_index] <= q_req.data;
        end
    end

    // Decision registered in the pop cycle
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            hit_valid  <= 1'b0;
            miss_valid <= 1'b0;
        end else begin
            hit_valid  <= q_ready && load_hit;
            miss_valid <= q_ready && to_miss_path;
        end
    end

    always_ff @(posedge clock) begin
        if (q_ready) begin
            hit_resp <= '{id: q_req.id, data: line_word[probe_index]};
            miss_req <= q_req;
        end
    end

endmodule

`default_nettype wire

/* hw/miss_handler.sv */
`default_nettype none

`include "dcache_config.svh"

module miss_handler
    import dcache_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         squash,
    input  logic         miss_valid,
    input  dc_req_t      miss_req,
    input  line_tag_t    probe_tag,
    input  line_index_t  probe_index,
    input  mem_tag_t     mem_transaction_tag,
    input  word_t        mem_data,
    input  mem_tag_t     mem_data_tag,
    output logic         miss_ready,
    output logic         line_busy,
    output mem_command_t mem_command,
    output addr_t        mem_addr,
    output word_t        mem_wdata,
    output logic         fill_valid,
    output line_index_t  fill_index,
    output line_tag_t    fill_tag,
    output word_t        fill_data,
    output logic         miss_resp_valid,
    output dc_resp_t     miss_resp
);

    localparam int SLOT_BITS = (`DC_MSHRS > 1) ? $clog2(`DC_MSHRS) : 1;

    typedef logic [SLOT_BITS-1:0] slot_t;

    miss_entry_t entries [`DC_MSHRS];
    miss_order_t next_order;

    slot_t       free_slot;
    slot_t       issue_slot;
    slot_t       ret_slot;
    logic        issue_any;
    logic        ret_any;
    logic        mem_accept;
    miss_entry_t issue_entry;

    // Lowest free entry, and room beyond the one being allocated now
    always_comb begin
        int free_count;
        free_count = 0;
        free_slot  = '0;
        for (int i = `DC_MSHRS - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                free_slot  = slot_t'(i);
                free_count = free_count + 1;
            end
        end
        miss_ready = free_count > (miss_valid ? 1 : 0);
    end

    // Oldest unissued entry has the largest age
    always_comb begin
        miss_order_t age;
        miss_order_t best_age;
        issue_any  = 1'b0;
        issue_slot = '0;
        best_age   = '0;
        for (int i = 0; i < `DC_MSHRS; i++) begin
            age = next_order - entries[i].order;
            if (entries[i].valid && !entries[i].issued && (!issue_any || age > best_age)) begin
                issue_any  = 1'b1;
                issue_slot = slot_t'(i);
                best_age   = age;
            end
        end
    end

    always_comb begin
        ret_any  = 1'b0;
        ret_slot = '0;
        for (int i = 0; i < `DC_MSHRS; i++) begin
            if (entries[i].valid && entries[i].issued && !entries[i].is_store &&
                mem_data_tag != '0 && entries[i].mem_tag == mem_data_tag) begin
                ret_any  = 1'b1;
                ret_slot = slot_t'(i);
            end
        end
    end

    // Line stays busy from hand-off until its fill has been written
    always_comb begin
        line_busy = fill_valid && fill_tag == probe_tag && fill_index == probe_index;
        if (miss_valid && addr_tag(miss_req.addr) == probe_tag &&
            addr_index(miss_req.addr) == probe_index) begin
            line_busy = 1'b1;
        end
        for (int i = 0; i < `DC_MSHRS; i++) begin
            if (entries[i].valid && addr_tag(entries[i].addr) == probe_tag &&
                addr_index(entries[i].addr) == probe_index) begin
                line_busy = 1'b1;
            end
        end
    end

    assign issue_entry = entries[issue_slot];
    assign mem_accept  = issue_any && (mem_transaction_tag != '0);

    always_comb begin
        mem_command = MEM_NONE;
        mem_addr    = '0;
        mem_wdata   = '0;
        if (issue_any) begin
            mem_command = issue_entry.is_store ? MEM_STORE : MEM_LOAD;
            mem_addr    = {issue_entry.addr[31:`DC_OFFSET_BITS], {`DC_OFFSET_BITS{1'b0}}};
            mem_wdata   = issue_entry.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_MSHRS; i++) begin
                entries[i].valid    <= 1'b0;
                entries[i].issued   <= 1'b0;
                entries[i].squashed <= 1'b0;
            end
            next_order      <= '0;
            fill_valid      <= 1'b0;
            miss_resp_valid <= 1'b0;
        end else begin
            if (squash) begin
                for (int i = 0; i < `DC_MSHRS; i++) begin
                    entries[i].squashed <= 1'b1;
                end
            end
            // Stores are done once memory takes them
            if (mem_accept) begin
                if (issue_entry.is_store) begin
                    entries[issue_slot].valid <= 1'b0;
                end else begin
                    entries[issue_slot].issued  <= 1'b1;
                    entries[issue_slot].mem_tag <= mem_transaction_tag;
                end
            end
            if (ret_any) begin
                entries[ret_slot].valid <= 1'b0;
            end
            if (miss_valid) begin
                entries[free_slot] <= '{
                    valid:    1'b1,
                    issued:   1'b0,
                    squashed: squash,
                    is_store: miss_req.is_store,
                    order:    next_order,
                    mem_tag:  '0,
                    id:       miss_req.id,
                    addr:     miss_req.addr,
                    data:     miss_req.data
                };
                next_order <= next_order + 1'b1;
            end
            fill_valid      <= ret_any;
            miss_resp_valid <= ret_any && !entries[ret_slot].squashed && !squash;
        end
    end

    always_ff @(posedge clock) begin
        if (ret_any) begin
            fill_index <= addr_index(entries[ret_slot].addr);
            fill_tag   <= addr_tag(entries[ret_slot].addr);
            fill_data  <= mem_data;
            miss_resp  <= '{id: entries[ret_slot].id, data: mem_data};
        end
    end

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  logic    [`DC_PORTS-1:0]  req_valid,
    input  dc_req_t [`DC_PORTS-1:0]  req,
    input  mem_tag_t                 mem_transaction_tag,
    input  word_t                    mem_data,
    input  mem_tag_t                 mem_data_tag,
    output logic    [`DC_PORTS-1:0]  req_accept,
    output logic     [1:0]           resp_valid,
    output dc_resp_t [1:0]           resp,
    output mem_command_t             mem_command,
    output addr_t                    mem_addr,
    output word_t                    mem_wdata
);

    logic        q_valid;
    dc_req_t     q_req;
    logic        q_ready;
    line_tag_t   probe_tag;
    line_index_t probe_index;
    logic        line_busy;
    logic        miss_valid;
    dc_req_t     miss_req;
    logic        miss_ready;
    logic        fill_valid;
    line_index_t fill_index;
    line_tag_t   fill_tag;
    word_t       fill_data;

    req_queue #(
        .DEPTH(`DC_QUEUE_DEPTH)
    ) queue (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .push_valid  (req_valid),
        .push_req    (req),
        .pop         (q_ready),
        .push_accept (req_accept),
        .head_valid  (q_valid),
        .head_req    (q_req)
    );

    // Lane 0 carries hits, lane 1 miss answers
    dcache_lookup lookup (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .q_valid     (q_valid),
        .q_req       (q_req),
        .line_busy   (line_busy),
        .miss_ready  (miss_ready),
        .fill_valid  (fill_valid),
        .fill_index  (fill_index),
        .fill_tag    (fill_tag),
        .fill_data   (fill_data),
        .q_ready     (q_ready),
        .probe_tag   (probe_tag),
        .probe_index (probe_index),
        .hit_valid   (resp_valid[0]),
        .hit_resp    (resp[0]),
        .miss_valid  (miss_valid),
        .miss_req    (miss_req)
    );

    miss_handler mshr (
        .clock               (clock),
        .reset               (reset),
        .squash              (squash),
        .miss_valid          (miss_valid),
        .miss_req            (miss_req),
        .probe_tag           (probe_tag),
        .probe_index         (probe_index),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .miss_ready          (miss_ready),
        .line_busy           (line_busy),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_wdata           (mem_wdata),
        .fill_valid          (fill_valid),
        .fill_index          (fill_index),
        .fill_tag            (fill_tag),
        .fill_data           (fill_data),
        .miss_resp_valid     (resp_valid[1]),
        .miss_resp           (resp[1])
    );

endmodule

`default_nettype wire

/* tests/dcache_asserts.sv */
`default_nettype none

module dcache_asserts
    import dcache_pkg::*;
(
    input logic            clock,
    input logic            reset,
    input logic     [1:0]  resp_valid,
    input dc_resp_t [1:0]  resp,
    input mem_command_t    mem_command,
    input addr_t           mem_addr,
    input word_t           mem_wdata,
    input mem_tag_t        mem_transaction_tag
);

    timeunit 1ns;
    timeprecision 1ps;

    valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(resp_valid))
    else $error("resp_valid is unknown");

    lane0_known: assert property (@(posedge clock) disable iff (reset)
        resp_valid[0] |-> !$isunknown(resp[0]))
    else $error("lane 0 answer carries X");

    lane1_known: assert property (@(posedge clock) disable iff (reset)
        resp_valid[1] |-> !$isunknown(resp[1]))
    else $error("lane 1 answer carries X");

    // A refused command is repeated unchanged
    refused_stable: assert property (@(posedge clock) disable iff (reset)
        (mem_command != MEM_NONE && mem_transaction_tag == '0) |=>
        (mem_command == $past(mem_command) && mem_addr == $past(mem_addr) &&
         mem_wdata == $past(mem_wdata)))
    else $error("memory command changed while refused");

    idle_after_reset: assert property (@(posedge clock)
        reset |=> (resp_valid == '0 && mem_command == MEM_NONE))
    else $error("outputs active in the cycle after reset");

endmodule

bind dcache_top dcache_asserts u_asserts (
    .clock               (clock),
    .reset               (reset),
    .resp_valid          (resp_valid),
    .resp                (resp),
    .mem_command         (mem_command),
    .mem_addr            (mem_addr),
    .mem_wdata           (mem_wdata),
    .mem_transaction_tag (mem_transaction_tag)
);

`default_nettype wire

/* tests/dcache_tb.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BURST_REQUESTS = 100;
    localparam int NUM_REQUESTS = BURST_REQUESTS + 30;
    localparam int MEM_WORDS = 1024;

    logic                          clock;
    logic                          reset;
    logic                          squash;
    logic     [`DC_PORTS-1:0]      req_valid;
    dc_req_t  [`DC_PORTS-1:0]      req;
    mem_tag_t                      mem_transaction_tag;
    word_t                         mem_data;
    mem_tag_t                      mem_data_tag;
    logic     [`DC_PORTS-1:0]      req_accept;
    logic     [1:0]                resp_valid;
    dc_resp_t [1:0]                resp;
    mem_command_t                  mem_command;
    addr_t                         mem_addr;
    word_t                         mem_wdata;

    int    seed = 32'hdcd9;
    int    cycle;
    int    errors;
    int    checks;
    int    refuse_pct;
    int    want_lane;
    bit    check_latency;
    bit    stalled;
    int    occupancy;

    // Memory model and program-order copy used for predictions
    word_t mem [MEM_WORDS];
    word_t shadow [MEM_WORDS];
    bit    tag_used [16];
    int    ret_tag [$];
    word_t ret_data [$];
    int    ret_due [$];
    int    load_cmds;
    int    store_cmds;
    int    commands_seen;
    int    refusals;
    addr_t last_load_addr;
    word_t last_store_data;

    // Scoreboard by request id
    bit      exp_valid [16];
    word_t   exp_data [16];
    int      exp_cycle [16];
    bit      id_busy [16];
    req_id_t id_ptr;
    bit      taken [`DC_PORTS];

    dcache_top i_dut (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle++;
    end

    function automatic int word_index(addr_t addr);
        return int'(addr[11:2]);
    endfunction

    function automatic int rand_below(int n);
        return (int'($random(seed)) & 32'h7fffffff) % n;
    endfunction

    function automatic bit alloc_id(output req_id_t id);
        id = '0;
        for (int i = 0; i < 16; i++) begin
            if (!id_busy[id_ptr]) begin
                id = id_ptr;
                id_busy[id_ptr] = 1'b1;
                id_ptr = id_ptr + 1'b1;
                return 1'b1;
            end
            id_ptr = id_ptr + 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += int'(exp_valid[i]);
        end
        return n;
    endfunction

    task automatic fail(string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic report(string name, int errors_before);
        $display("%-26s %0d errors", name, errors - errors_before);
    endtask

    // Memory answers the command in the same cycle
    task automatic serve_command();
        int t;
        int idx;
        mem_transaction_tag = '0;
        if (reset || mem_command == MEM_NONE) begin
            return;
        end
        commands_seen++;
        t = 0;
        for (int i = 1; i < 16; i++) begin
            if (t == 0 && !tag_used[i]) begin
                t = i;
            end
        end
        if (t == 0 || rand_below(100) < refuse_pct) begin
            refusals++;
            return;
        end
        idx = word_index(mem_addr);
        mem_transaction_tag = mem_tag_t'(t);
        if (mem_command == MEM_STORE) begin
            mem[idx] = mem_wdata;
            last_store_data = mem_wdata;
            store_cmds++;
        end else begin
            tag_used[t] = 1'b1;
            last_load_addr = mem_addr;
            load_cmds++;
            ret_tag.push_back(t);
            ret_data.push_back(mem[idx]);
            ret_due.push_back(cycle + 3 + rand_below(6));
        end
    endtask

    task automatic serve_return();
        mem_data_tag = '0;
        mem_data = '0;
        for (int i = 0; i < ret_due.size(); i++) begin
            if (ret_due[i] <= cycle) begin
                mem_data_tag = mem_tag_t'(ret_tag[i]);
                mem_data = ret_data[i];
                tag_used[ret_tag[i]] = 1'b0;
                ret_tag.delete(i);
                ret_data.delete(i);
                ret_due.delete(i);
                return;
            end
        end
    endtask

    always begin
        @(posedge clock);
        #2;
        serve_command();
        serve_return();
    end

    task automatic check_answers();
        req_id_t id;
        for (int l = 0; l < 2; l++) begin
            if (resp_valid[l]) begin
                id = resp[l].id;
                checks++;
                assert (exp_valid[id])
                else fail($sformatf("answer in lane %0d for id %0d with no load outstanding", l, id));
                if (exp_valid[id]) begin
                    assert (resp[l].data == exp_data[id])
                    else begin
                        errors++;
                        $display("MISMATCH resp[%0d].data id %0d: got %h expected %h",
                                 l, id, resp[l].data, exp_data[id]);
                    end
                    assert (want_lane < 0 || l == want_lane)
                    else fail($sformatf("load id %0d answered in lane %0d", id, l));
                    assert (!check_latency || cycle - exp_cycle[id] == 2)
                    else fail($sformatf("hit answered %0d cycles after acceptance",
                                        cycle - exp_cycle[id]));
                    exp_valid[id] = 1'b0;
                    id_busy[id] = 1'b0;
                end
            end
        end
    endtask

    task automatic track_requests();
        int n;
        int idx;
        n = 0;
        for (int p = 0; p < `DC_PORTS; p++) begin
            if (req_valid[p] && req_accept[p]) begin
                n++;
                taken[p] = 1'b1;
                idx = word_index(req[p].addr);
                if (req[p].is_store) begin
                    shadow[idx] = req[p].data;
                end else begin
                    exp_valid[req[p].id] = 1'b1;
                    exp_data[req[p].id] = shadow[idx];
                    exp_cycle[req[p].id] = cycle;
                end
            end else if (req_valid[p] && !squash) begin
                stalled = 1'b1;
            end
        end
        checks++;
        assert (n <= `DC_QUEUE_DEPTH - occupancy)
        else fail($sformatf("queue took %0d requests with %0d free slots",
                            n, `DC_QUEUE_DEPTH - occupancy));
        occupancy = squash ? 0 : occupancy + n - int'(i_dut.q_ready);
    endtask

    always @(negedge clock) begin
        if (!reset) begin
            check_answers();
            track_requests();
        end
    end

    // Holds the request until the queue takes it
    task automatic issue(int p, bit is_store, addr_t addr, word_t data);
        req_id_t id;
        id = '0;
        if (!is_store) begin
            void'(alloc_id(id));
        end
        req[p] = '{is_store: is_store, id: id, addr: addr, data: data};
        req_valid[p] = 1'b1;
        do begin
            @(posedge clock);
            #2;
        end while (!taken[p]);
        taken[p] = 1'b0;
        req_valid[p] = 1'b0;
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 12) begin
            @(posedge clock);
            #2;
            if (outstanding() == 0 && mem_command == MEM_NONE && ret_due.size() == 0) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic random_burst();
        int      sent;
        req_id_t id;
        bit      is_store;
        sent = 0;
        while (sent < BURST_REQUESTS || req_valid != '0) begin
            @(posedge clock);
            #2;
            for (int p = 0; p < `DC_PORTS; p++) begin
                if (req_valid[p] && taken[p]) begin
                    req_valid[p] = 1'b0;
                    taken[p] = 1'b0;
                end
                if (!req_valid[p] && sent < BURST_REQUESTS && rand_below(4) != 0) begin
                    is_store = (rand_below(4) == 0);
                    id = '0;
                    if (is_store || alloc_id(id)) begin
                        req[p] = '{is_store: is_store, id: id,
                                   addr: addr_t'(rand_below(48) * 4), data: $random(seed)};
                        req_valid[p] = 1'b1;
                        sent++;
                    end
                end
            end
        end
    endtask

    initial begin
        int e0;
        int c0;
        clock = 1'b0;
        reset = 1'b1;
        squash = 1'b0;
        req_valid = '0;
        req = '0;
        mem_transaction_tag = '0;
        mem_data = '0;
        mem_data_tag = '0;
        refuse_pct = 25;
        want_lane = -1;
        id_ptr = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
            shadow[i] = mem[i];
        end
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;

        e0 = errors;
        want_lane = 1;
        c0 = load_cmds;
        issue(0, 1'b0, 32'h100, '0);
        wait_idle();
        assert (load_cmds - c0 == 1 && last_load_addr == 32'h100)
        else fail("cold load did not issue exactly one MEM_LOAD to its word address");
        report("cold load miss", e0);

        e0 = errors;
        want_lane = 0;
        check_latency = 1'b1;
        c0 = commands_seen;
        issue(0, 1'b0, 32'h100, '0);
        wait_idle();
        assert (commands_seen == c0) else fail("repeat load sent a memory command");
        check_latency = 1'b0;
        want_lane = -1;
        report("repeat load hit", e0);

        e0 = errors;
        c0 = store_cmds;
        issue(1, 1'b1, 32'h100, 32'h5a5a_0001);
        issue(0, 1'b0, 32'h100, '0);
        issue(1, 1'b1, 32'h200, 32'h5a5a_0002);
        issue(0, 1'b0, 32'h200, '0);
        wait_idle();
        assert (store_cmds - c0 == 2 && last_store_data == 32'h5a5a_0002 &&
                mem[word_index(32'h100)] == 32'h5a5a_0001)
        else fail("stores did not reach memory with their data");
        report("store then load", e0);

        e0 = errors;
        stalled = 1'b0;
        random_burst();
        wait_idle();
        assert (stalled) else fail("burst never reached back-pressure");
        report("random two-port burst", e0);

        // Heavy refusal on cold lines
        e0 = errors;
        c0 = refusals;
        refuse_pct = 60;
        for (int i = 0; i < 12; i++) begin
            issue(i % 2, 1'b0, addr_t'(32'h400 + 4 * i), '0);
        end
        wait_idle();
        refuse_pct = 25;
        assert (refusals > c0) else fail("no memory command was refused");
        report("memory refusal", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            issue(0, 1'b0, addr_t'(32'h800 + 4 * i), '0);
        end
        squash = 1'b1;
        @(posedge clock);
        #2;
        squash = 1'b0;
        for (int i = 0; i < 16; i++) begin
            exp_valid[i] = 1'b0;
            id_busy[i] = 1'b0;
        end
        for (int i = 0; i < 6; i++) begin
            issue(1, 1'b0, addr_t'(32'h800 + 4 * i), '0);
        end
        wait_idle();
        report("squash", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (40 * NUM_REQUESTS + 200) @(posedge clock);
        $display("Timeout: the run did not finish within the cycle limit");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/dcache_pkg.sv
hw/req_queue.sv
hw/dcache_lookup.sv
hw/miss_handler.sv
hw/dcache_top.sv
tests/dcache_asserts.sv
tests/dcache_tb.sv

/* Makefile */
SIM := obj_dir/Vdcache_tb

.PHONY: run clean

run: $(SIM)
	out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

$(SIM): project.f $(wildcard hw/*.sv hw/*.svh tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f project.f

clean:
	rm -rf obj_dir
